// ==== Bender.yml ====
package:
  name: rsa256

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - rsa_pkg.sv
      - avm_req_if.sv
      - rsa_rx_loader.sv
      - rsa_tx_sender.sv
      - rsa_avm_arbiter.sv
      - rsa_mod_prep.sv
      - rsa_mont_mul.sv
      - rsa256_core.sv
      - rsa256_wrapper.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - rsa256_wrapper_tb.sv

// ==== avm_req_if.sv ====
`timescale 1ns/10ps
`include "rsa_settings.svh"

// one avalon-mm request path between a master FSM and the arbiter
interface avm_req_if;

    logic [`AVM_ADDR_W-1:0] address;
    logic                   read;
    logic                   write;
    logic [`AVM_DATA_W-1:0] writedata;
    logic [`AVM_DATA_W-1:0] readdata;
    logic                   waitrequest;

    // the master drives the next request, the arbiter registers it
    modport master (
        output address, read, write, writedata,
        input  readdata, waitrequest
    );

    modport slave (
        input  address, read, write, writedata,
        output readdata, waitrequest
    );

endinterface

// ==== flist.f ====
+incdir+.
rsa_pkg.sv
avm_req_if.sv
rsa_rx_loader.sv
rsa_tx_sender.sv
rsa_avm_arbiter.sv
rsa_mod_prep.sv
rsa_mont_mul.sv
rsa256_core.sv
rsa256_wrapper.sv
rsa256_wrapper_tb.sv

// ==== rsa256_core.sv ====
`timescale 1ns/10ps
`include "rsa_settings.svh"

module rsa256_core (
    input  logic              avm_clk,
    input  logic              avm_rst,
    input  logic              start,
    input  logic [`RSA_W-1:0] enc,
    input  logic [`RSA_W-1:0] d,
    input  logic [`RSA_W-1:0] n,
    output logic [`RSA_W-1:0] result,
    output logic              finished
);

    rsa_pkg::core_state_e      state;
    logic [$clog2(`RSA_W)-1:0] bit_idx;
    logic [`RSA_W-1:0]         base;    // montgomery form
    logic [`RSA_W-1:0]         acc;     // plain form
    logic                      prep_start, prep_finished;
    logic                      mul_start, sq_finished, mul_finished;
    logic [`RSA_W-1:0]         prep_result, sq_result, mul_result;

    assign prep_start = (state == rsa_pkg::core_idle) && start;
    assign mul_start  = (state == rsa_pkg::core_loop_square);
    assign finished   = (state == rsa_pkg::core_done);

    rsa_mod_prep prep_i (
        .avm_clk (avm_clk), .avm_rst (avm_rst), .start (prep_start),
        .a (enc), .n (n), .result (prep_result), .finished (prep_finished)
    );

    rsa_mont_mul square_i (
        .avm_clk (avm_clk), .avm_rst (avm_rst), .start (mul_start),
        .a (base), .b (base), .n (n), .result (sq_result), .finished (sq_finished)
    );

    // acc * base * 2^-256 keeps acc out of montgomery form
    rsa_mont_mul mult_i (
        .avm_clk (avm_clk), .avm_rst (avm_rst), .start (mul_start),
        .a (acc), .b (base), .n (n), .result (mul_result), .finished (mul_finished)
    );

    // ============================================================
    // square and multiply, lsb of d first
    // ============================================================
    always_ff @(posedge avm_clk or negedge avm_rst) begin
        if (!avm_rst) begin
            state   <= rsa_pkg::core_idle;
            bit_idx <= '0;
        end else begin
            case (state)
                rsa_pkg::core_idle:        if (start) state <= rsa_pkg::core_prep;
                rsa_pkg::core_prep: begin
                    if (prep_finished) begin
                        state   <= rsa_pkg::core_loop_square;
                        bit_idx <= '0;
                    end
                end
                rsa_pkg::core_loop_square: state <= rsa_pkg::core_loop_mult;
                rsa_pkg::core_loop_mult: begin
                    if (sq_finished && mul_finished) begin
                        bit_idx <= bit_idx + 1'b1;
                        state   <= (&bit_idx) ? rsa_pkg::core_final
                                              : rsa_pkg::core_loop_square;
                    end
                end
                rsa_pkg::core_final:       state <= rsa_pkg::core_done;
                default:                   state <= rsa_pkg::core_idle;
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        if (state == rsa_pkg::core_prep && prep_finished) begin
            base <= prep_result;
            acc  <= `RSA_W'(1);
        end else if (state == rsa_pkg::core_loop_mult && sq_finished && mul_finished) begin
            base <= sq_result;
            if (d[bit_idx]) acc <= mul_result;
        end
        if (state == rsa_pkg::core_final) result <= acc;
    end

    // a new block only arrives once the previous result is handed over
    a_start_when_idle: assert property (@(posedge avm_clk) disable iff (!avm_rst)
        start |-> state == rsa_pkg::core_idle);

endmodule

// ==== rsa256_wrapper.sv ====
`timescale 1ns/10ps
`include "rsa_settings.svh"

module rsa256_wrapper (
    input  logic                   avm_rst,
    input  logic                   avm_clk,
    output logic [`AVM_ADDR_W-1:0] avm_address,
    output logic                   avm_read,
    input  logic [`AVM_DATA_W-1:0] avm_readdata,
    output logic                   avm_write,
    output logic [`AVM_DATA_W-1:0] avm_writedata,
    input  logic                   avm_waitrequest
);

    logic [`RSA_W-1:0] n, d, enc, dec;
    logic              block_valid;
    logic              finished;
    logic              tx_done;

    avm_req_if rx_bus ();
    avm_req_if tx_bus ();

    rsa_rx_loader loader_i (
        .avm_clk (avm_clk), .avm_rst (avm_rst), .bus (rx_bus.master),
        .n (n), .d (d), .enc (enc), .block_valid (block_valid)
    );

    rsa256_core core_i (
        .avm_clk (avm_clk), .avm_rst (avm_rst), .start (block_valid),
        .enc (enc), .d (d), .n (n), .result (dec), .finished (finished)
    );

    rsa_tx_sender sender_i (
        .avm_clk (avm_clk), .avm_rst (avm_rst), .bus (tx_bus.master),
        .result (dec), .start (finished), .tx_done (tx_done)
    );

    rsa_avm_arbiter arbiter_i (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .rx_bus          (rx_bus.slave),
        .tx_bus          (tx_bus.slave),
        .to_rx           (tx_done),
        .to_tx           (block_valid),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_readdata    (avm_readdata),
        .avm_waitrequest (avm_waitrequest)
    );

endmodule

// ==== rsa256_wrapper_tb.sv ====
`timescale 1ns/10ps
`include "rsa_settings.svh"

module rsa256_wrapper_tb;

    localparam int MAX_CASES  = 16;
    localparam int BLOCK_CYC  = 140000;     // one exponentiation plus polling
    localparam int MARGIN_CYC = 20000;

    logic                   avm_clk         = 1'b0;
    logic                   avm_rst         = 1'b0;
    logic [`AVM_DATA_W-1:0] avm_readdata    = '0;
    logic                   avm_waitrequest = 1'b1;
    logic [`AVM_ADDR_W-1:0] avm_address;
    logic                   avm_read;
    logic                   avm_write;
    logic [`AVM_DATA_W-1:0] avm_writedata;

    // four words per case: n, d, enc, expected
    logic [`RSA_W-1:0] vec_mem [0:4*MAX_CASES-1];
    int                num_cases   = 0;
    int                cycle_limit = 0;
    int                cycle_cnt   = 0;
    integer            seed        = 32'ha757_6cb4;

    // serial peripheral model
    logic [7:0]  rx_q [$];
    logic [7:0]  last_status = '0;      // value of the latest completed status read
    logic [7:0]  status;
    logic [7:0]  rx_byte;
    logic [7:0]  exp_byte;
    logic [31:0] rnd;
    logic        seen_reset  = 1'b0;
    logic        rx_offered  = 1'b0;    // a status read has shown a receive byte
    logic        tx_due      = 1'b0;    // block fully read, result bytes may follow
    int          case_idx    = 0;
    int          wr_idx      = 0;

    rsa256_wrapper dut_i (
        .avm_rst         (avm_rst),
        .avm_clk         (avm_clk),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_readdata    (avm_readdata),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest)
    );

    always #5 avm_clk = ~avm_clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error at %0t: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            $display("test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s, at %0t", why, $time);
        $display("test failed");
        $fatal(1, "%s", why);
    endtask

    // most significant byte goes out first
    task automatic queue_block(input logic [`RSA_W-1:0] value);
        for (int i = `RSA_BYTES - 1; i >= 0; i--) begin
            rx_q.push_back(value[8*i +: 8]);
        end
    endtask

    always @(posedge avm_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            abort_run($sformatf("run timed out after %0d cycles with %0d of %0d cases done",
                                cycle_cnt, case_idx, num_cases));
        end
    end

    // ============================================================
    // peripheral: decides each access on the falling edge
    // ============================================================
    always @(negedge avm_clk) begin
        if (!avm_rst) begin
            seen_reset = 1'b1;
            check_value("avm_write", avm_write, 0);
            avm_waitrequest <= 1'b1;
            avm_readdata    <= '0;
        end else if (seen_reset) begin
            rnd = $random(seed);
            check_value("avm_read && avm_write", avm_read && avm_write, 0);
            if (!rx_offered) begin
                check_value("avm_write", avm_write, 0);
                if (avm_read) check_value("avm_address", avm_address, `STATUS_BASE);
            end
            avm_waitrequest <= 1'b0;
            avm_readdata    <= '0;
            if ((avm_read || avm_write) && rnd[1:0] == 2'd0) begin
                avm_waitrequest <= 1'b1;                // stall, request must hold
            end else if (avm_read && avm_address == `STATUS_BASE) begin
                status = 8'h00;
                status[`RX_OK_BIT] = (rx_q.size() != 0) && rnd[2];
                status[`TX_OK_BIT] = rnd[3];
                if (status[`RX_OK_BIT]) rx_offered = 1'b1;
                last_status = status;
                avm_readdata <= `AVM_DATA_W'(status);
            end else if (avm_read && avm_address == `RX_BASE) begin
                if (!last_status[`RX_OK_BIT]) begin
                    abort_run("receive register read without a ready status before it");
                end
                rx_byte = rx_q.pop_front();
                avm_readdata <= `AVM_DATA_W'(rx_byte);
                last_status = '0;
                if (rx_q.size() == 0) tx_due = 1'b1;
            end else if (avm_write) begin
                check_value("avm_address", avm_address, `TX_BASE);
                if (!tx_due) abort_run("transmit register written while no result was due");
                if (!last_status[`TX_OK_BIT]) begin
                    abort_run("transmit register written without a ready status before it");
                end
                last_status = '0;
                exp_byte = vec_mem[4*case_idx+3][8*(`RSA_TX_BYTES-1-wr_idx) +: 8];
                check_value("avm_writedata", avm_writedata[7:0], exp_byte);
                wr_idx++;
                if (wr_idx == `RSA_TX_BYTES) begin
                    $display("case %0d: %0d result bytes received", case_idx, wr_idx);
                    wr_idx = 0;
                    tx_due = 1'b0;
                    case_idx++;
                    if (case_idx < num_cases) queue_block(vec_mem[4*case_idx+2]);
                end
            end else if (avm_read) begin
                abort_run("read of an address the peripheral does not decode");
            end
        end
    end

    initial begin
        $timeformat(-9, 1, " ns", 0);
        $readmemh("rsa_cases.txt", vec_mem);
        while (num_cases < MAX_CASES && !$isunknown(vec_mem[4*num_cases])
               && vec_mem[4*num_cases] != '0) begin
            num_cases++;
        end
        if (num_cases == 0) abort_run("no test vectors found in rsa_cases.txt");
        cycle_limit = num_cases * BLOCK_CYC + MARGIN_CYC;

        // key and first ciphertext, later cases only add enc
        queue_block(vec_mem[0]);
        queue_block(vec_mem[1]);
        queue_block(vec_mem[2]);

        repeat (10) @(negedge avm_clk);
        avm_rst <= 1'b1;

        wait (case_idx == num_cases);
        repeat (200) @(negedge avm_clk);    // stray accesses get caught by the model

        $display("test passed");
        $finish;
    end

endmodule

// ==== rsa_avm_arbiter.sv ====
`timescale 1ns/10ps
`include "rsa_settings.svh"

module rsa_avm_arbiter (
    input  logic                   avm_clk,
    input  logic                   avm_rst,
    avm_req_if.slave               rx_bus,
    avm_req_if.slave               tx_bus,
    input  logic                   to_rx,
    input  logic                   to_tx,
    output logic [`AVM_ADDR_W-1:0] avm_address,
    output logic                   avm_read,
    output logic                   avm_write,
    output logic [`AVM_DATA_W-1:0] avm_writedata,
    input  logic [`AVM_DATA_W-1:0] avm_readdata,
    input  logic                   avm_waitrequest
);

    rsa_pkg::port_owner_e owner, owner_nxt;

    always_comb begin
        owner_nxt = owner;
        if (to_tx)      owner_nxt = rsa_pkg::owner_tx;
        else if (to_rx) owner_nxt = rsa_pkg::owner_rx;
    end

    assign rx_bus.readdata    = avm_readdata;
    assign tx_bus.readdata    = avm_readdata;
    // the idle master sees a stalled port
    assign rx_bus.waitrequest = (owner == rsa_pkg::owner_rx) ? avm_waitrequest : 1'b1;
    assign tx_bus.waitrequest = (owner == rsa_pkg::owner_tx) ? avm_waitrequest : 1'b1;

    // register the request of whoever owns the port next cycle
    always_ff @(posedge avm_clk or negedge avm_rst) begin
        if (!avm_rst) begin
            owner       <= rsa_pkg::owner_rx;
            avm_address <= `STATUS_BASE;
            avm_read    <= 1'b1;
            avm_write   <= 1'b0;
        end else begin
            owner <= owner_nxt;
            if (owner_nxt == rsa_pkg::owner_rx) begin
                avm_address <= rx_bus.address;
                avm_read    <= rx_bus.read;
                avm_write   <= rx_bus.write;
            end else begin
                avm_address <= tx_bus.address;
                avm_read    <= tx_bus.read;
                avm_write   <= tx_bus.write;
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        avm_writedata <= (owner_nxt == rsa_pkg::owner_rx) ? rx_bus.writedata
                                                           : tx_bus.writedata;
    end

    // handover strobes only arrive while the port is quiet
    a_owner_stable: assert property (@(posedge avm_clk) disable iff (!avm_rst)
        avm_waitrequest && (avm_read || avm_write) |-> owner_nxt == owner);

endmodule

// ==== rsa_cases.txt ====
// columns: n d enc expected, each a 256-bit hex word, one case per line
// the key repeats on every line, only the first line's n and d are sent to the DUT
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 3c5a9e71b2d4f0861a7c3e95d0b24f68e317a9c4560bd2f89a4c1e7d3b55 2 2000000000000000000000000000000000000000000000000000000000
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 3c5a9e71b2d4f0861a7c3e95d0b24f68e317a9c4560bd2f89a4c1e7d3b55 80 80000000000000000000000000000000000000000
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 3c5a9e71b2d4f0861a7c3e95d0b24f68e317a9c4560bd2f89a4c1e7d3b55 fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffe fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffe
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 3c5a9e71b2d4f0861a7c3e95d0b24f68e317a9c4560bd2f89a4c1e7d3b55 fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffd ffdfffffffffffffffffffffffffffffffffffffffffffffffffffffffff
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 3c5a9e71b2d4f0861a7c3e95d0b24f68e317a9c4560bd2f89a4c1e7d3b55 800000000000000000000000000000000000000000000000000000000000 800
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 3c5a9e71b2d4f0861a7c3e95d0b24f68e317a9c4560bd2f89a4c1e7d3b55 1 1

// ==== rsa_mod_prep.sv ====
`timescale 1ns/10ps
`include "rsa_settings.svh"

// a * 2^256 mod n, one doubling per cycle
module rsa_mod_prep (
    input  logic              avm_clk,
    input  logic              avm_rst,
    input  logic              start,
    input  logic [`RSA_W-1:0] a,
    input  logic [`RSA_W-1:0] n,
    output logic [`RSA_W-1:0] result,
    output logic              finished
);

    logic                      busy;
    logic [$clog2(`RSA_W)-1:0] cnt;
    logic [`RSA_W-1:0]         r;       // running value, stays below n
    logic [`RSA_W:0]           dbl;
    logic [`RSA_W:0]           diff;

    assign dbl    = {r, 1'b0};
    assign diff   = dbl - {1'b0, n};
    assign result = r;

    always_ff @(posedge avm_clk or negedge avm_rst) begin
        if (!avm_rst) begin
            busy     <= 1'b0;
            cnt      <= '0;
            finished <= 1'b0;
        end else begin
            finished <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (&cnt) begin         // 256th doubling
                    busy     <= 1'b0;
                    finished <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (start)     r <= a;
        else if (busy) r <= (dbl >= {1'b0, n}) ? diff[`RSA_W-1:0] : dbl[`RSA_W-1:0];
    end

endmodule

// ==== rsa_mont_mul.sv ====
`timescale 1ns/10ps
`include "rsa_settings.svh"

// bit-serial montgomery product a*b*2^-256 mod n
module rsa_mont_mul (
    input  logic              avm_clk,
    input  logic              avm_rst,
    input  logic              start,
    input  logic [`RSA_W-1:0] a,
    input  logic [`RSA_W-1:0] b,
    input  logic [`RSA_W-1:0] n,
    output logic [`RSA_W-1:0] result,
    output logic              finished
);

    logic                    busy;
    logic [$clog2(`RSA_W):0] cnt;       // top bit set means final subtraction
    logic [`RSA_W-1:0]       a_sh;
    logic [`RSA_W+1:0]       m;         // partial sum, below 2n
    logic [`RSA_W+1:0]       sum;
    logic [`RSA_W+1:0]       sum_n;
    logic [`RSA_W+1:0]       diff;

    assign sum   = m + (a_sh[0] ? {2'b00, b} : '0);
    assign sum_n = sum[0] ? sum + {2'b00, n} : sum;     // make it even
    assign diff  = m - {2'b00, n};

    always_ff @(posedge avm_clk or negedge avm_rst) begin
        if (!avm_rst) begin
            busy     <= 1'b0;
            cnt      <= '0;
            finished <= 1'b0;
        end else begin
            finished <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt[$clog2(`RSA_W)]) begin
                    busy     <= 1'b0;
                    finished <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (start) begin
            m    <= '0;
            a_sh <= a;
        end else if (busy) begin
            if (cnt[$clog2(`RSA_W)]) begin
                // borrow out of diff means m < n
                result <= diff[`RSA_W+1] ? m[`RSA_W-1:0] : diff[`RSA_W-1:0];
            end else begin
                m    <= sum_n >> 1;
                a_sh <= a_sh >> 1;
            end
        end
    end

endmodule

// ==== rsa_pkg.sv ====
package rsa_pkg;

    // loader FSM
    typedef enum logic [1:0] {
        rx_poll,
        rx_read,
        rx_done
    } rx_state_e;

    // sender FSM
    typedef enum logic [1:0] {
        tx_idle,
        tx_poll,
        tx_write
    } tx_state_e;

    // which master drives the avalon port
    typedef enum logic {
        owner_rx,
        owner_tx
    } port_owner_e;

    // exponentiation FSM
    typedef enum logic [2:0] {
        core_idle,
        core_prep,
        core_loop_square,
        core_loop_mult,
        core_final,
        core_done
    } core_state_e;

endpackage

// ==== rsa_rx_loader.sv ====
`timescale 1ns/10ps
`include "rsa_settings.svh"

module rsa_rx_loader (
    input  logic              avm_clk,
    input  logic              avm_rst,
    avm_req_if.master         bus,
    output logic [`RSA_W-1:0] n,
    output logic [`RSA_W-1:0] d,
    output logic [`RSA_W-1:0] enc,
    output logic              block_valid
);

    rsa_pkg::rx_state_e state, state_nxt;
    logic [6:0]         cnt;        // byte position, counts down from 95
    logic               rx_ready;
    logic               done_rd;    // data read completes at this edge
    logic               last_byte;

    assign rx_ready  = !bus.waitrequest && bus.readdata[`RX_OK_BIT];
    assign done_rd   = (state == rsa_pkg::rx_read) && !bus.waitrequest;
    assign last_byte = (cnt == 7'd0);

    // next request, registered by the arbiter
    always_comb begin
        state_nxt     = state;
        bus.read      = 1'b1;
        bus.write     = 1'b0;
        bus.address   = `STATUS_BASE;
        bus.writedata = '0;
        case (state)
            rsa_pkg::rx_poll: begin
                if (rx_ready) begin
                    state_nxt   = rsa_pkg::rx_read;
                    bus.address = `RX_BASE;
                end
            end
            rsa_pkg::rx_read: begin
                if (!bus.waitrequest) begin
                    state_nxt = last_byte ? rsa_pkg::rx_done : rsa_pkg::rx_poll;
                    bus.read  = !last_byte;     // port goes quiet after the last byte
                end else begin
                    bus.address = `RX_BASE;     // hold the data read
                end
            end
            default: begin
                // block handed over, keep polling until the port comes back
                state_nxt = rsa_pkg::rx_poll;
            end
        endcase
    end

    always_ff @(posedge avm_clk or negedge avm_rst) begin
        if (!avm_rst) begin
            state       <= rsa_pkg::rx_poll;
            cnt         <= 7'(3 * `RSA_BYTES - 1);
            block_valid <= 1'b0;
        end else begin
            state       <= state_nxt;
            block_valid <= done_rd && last_byte;
            if (done_rd) begin
                // later blocks only refill enc, the key stays
                cnt <= last_byte ? 7'(`RSA_BYTES - 1) : cnt - 7'd1;
            end
        end
    end

    // cnt[6:5] picks n, d or enc; cnt[4:0] is the byte inside it
    always_ff @(posedge avm_clk) begin
        if (done_rd) begin
            case (cnt[6:5])
                2'b10:   n[{cnt[4:0], 3'b000} +: 8]   <= bus.readdata[7:0];
                2'b01:   d[{cnt[4:0], 3'b000} +: 8]   <= bus.readdata[7:0];
                default: enc[{cnt[4:0], 3'b000} +: 8] <= bus.readdata[7:0];
            endcase
        end
    end

    // a completed data read carries a known byte
    a_rd_data_known: assert property (@(posedge avm_clk) disable iff (!avm_rst)
        done_rd |-> !$isunknown(bus.readdata[7:0]));

endmodule

// ==== rsa_settings.svh ====
`ifndef RSA_SETTINGS_SVH
`define RSA_SETTINGS_SVH

// ============================================================
// block geometry
// ============================================================
`define RSA_W        256    // key and data width in bits
`define RSA_BYTES    32     // bytes per block
`define RSA_TX_BYTES 31     // top byte of a result is always zero

// ============================================================
// avalon master port and serial peripheral map
// ============================================================
`define AVM_ADDR_W   5
`define AVM_DATA_W   32

`define RX_BASE      5'd0
`define TX_BASE      5'd4
`define STATUS_BASE  5'd8

`define TX_OK_BIT    6
`define RX_OK_BIT    7

`endif

// ==== rsa_tx_sender.sv ====
`timescale 1ns/10ps
`include "rsa_settings.svh"

module rsa_tx_sender (
    input  logic              avm_clk,
    input  logic              avm_rst,
    avm_req_if.master         bus,
    input  logic [`RSA_W-1:0] result,
    input  logic              start,
    output logic              tx_done
);

    rsa_pkg::tx_state_e state, state_nxt;
    logic [`RSA_W-1:0]  shift;
    logic [4:0]         left;       // bytes still to send after this one
    logic               wr_done;

    assign wr_done       = (state == rsa_pkg::tx_write) && !bus.waitrequest;
    assign bus.writedata = {{(`AVM_DATA_W-8){1'b0}}, shift[`RSA_W-9 -: 8]};

    always_comb begin
        state_nxt   = state;
        bus.read    = 1'b0;
        bus.write   = 1'b0;
        bus.address = `STATUS_BASE;
        case (state)
            rsa_pkg::tx_idle: begin
                if (start) begin
                    state_nxt = rsa_pkg::tx_poll;
                    bus.read  = 1'b1;
                end
            end
            rsa_pkg::tx_poll: begin
                if (!bus.waitrequest && bus.readdata[`TX_OK_BIT]) begin
                    state_nxt   = rsa_pkg::tx_write;
                    bus.write   = 1'b1;
                    bus.address = `TX_BASE;
                end else begin
                    bus.read = 1'b1;            // poll again
                end
            end
            rsa_pkg::tx_write: begin
                if (!bus.waitrequest) begin
                    state_nxt = (left == 5'd0) ? rsa_pkg::tx_idle : rsa_pkg::tx_poll;
                    bus.read  = (left != 5'd0);
                end else begin
                    bus.write   = 1'b1;
                    bus.address = `TX_BASE;
                end
            end
            default: state_nxt = rsa_pkg::tx_idle;
        endcase
    end

    always_ff @(posedge avm_clk or negedge avm_rst) begin
        if (!avm_rst) begin
            state   <= rsa_pkg::tx_idle;
            left    <= '0;
            tx_done <= 1'b0;
        end else begin
            state   <= state_nxt;
            tx_done <= wr_done && (left == 5'd0);
            if (state == rsa_pkg::tx_idle && start) begin
                left <= 5'(`RSA_TX_BYTES - 1);
            end else if (wr_done) begin
                left <= left - 5'd1;
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (state == rsa_pkg::tx_idle && start) shift <= result;
        else if (wr_done)                       shift <= shift << 8;
    end

    // a new result only arrives once the previous block is out
    a_start_when_idle: assert property (@(posedge avm_clk) disable iff (!avm_rst)
        start |-> state == rsa_pkg::tx_idle);

endmodule
